// File: design/rx_frame_engine.sv
//--------------------------------------------------------------------
// uart frame engine: phase counter, frame FSM, bit counter,
// shift register, parity fold and stop bit check
//--------------------------------------------------------------------
`timescale 1ns/1ps

module rx_frame_engine
(
  input  logic                 clk,
  input  logic                 aresetn,
  input  logic                 baud_tick,   // 16x bit rate strobe
  input  logic                 rx_filtered, // filtered serial line
  input  logic                 bit8,        // 1: 8 data bits, 0: 7
  input  logic                 parity_en,   // parity bit present
  input  logic                 odd_n_even,  // 1: odd parity, 0: even
  output logic                 byte_done,   // one clk, last bit taken
  output uart_rx_pkg::rx_byte_t rx_data,    // valid with byte_done
  output logic                 parity_bad,  // valid with byte_done
  output logic                 frame_bad    // one clk, stop bit low
);

  uart_rx_pkg::rx_state_t      state;
  uart_rx_pkg::phase_t         phase;       // ticks into current bit
  uart_rx_pkg::bit_cnt_t       bit_cnt;     // bits sampled this frame
  uart_rx_pkg::bit_cnt_t       last_bit;    // frame length in bits
  logic [uart_rx_pkg::DATA_W:0] rx_shift;   // data plus parity, right aligned
  logic                        parity_calc; // running xor of sampled bits
  logic                        sample_now;
  logic                        last_taken;

  // mid-bit sample point of a data or parity bit
  assign sample_now = baud_tick && (state == uart_rx_pkg::data_bits) &&
                      (phase == uart_rx_pkg::phase_t'(uart_rx_pkg::SAMPLE_PHASE));

  // whole frame shifted in
  assign last_taken = baud_tick && (state == uart_rx_pkg::data_bits) &&
                      (bit_cnt == last_bit);

  //------------------------------------------------------------------
  // phase counter
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      phase <= '0;
    end
    else if (baud_tick)
    begin
      if ((state == uart_rx_pkg::idle) &&
          (rx_filtered || phase == uart_rx_pkg::phase_t'(uart_rx_pkg::START_MID)))
        phase <= '0; // line idle, or start bit confirmed at its middle
      else if ((state == uart_rx_pkg::wait_state) &&
               (phase == uart_rx_pkg::phase_t'(uart_rx_pkg::WAIT_LIMIT)))
        phase <= '0;
      else if (phase == uart_rx_pkg::phase_t'(uart_rx_pkg::TICKS_PER_BIT - 1))
        phase <= '0;
      else
        phase <= phase + 1'b1;
    end
  end

  //------------------------------------------------------------------
  // frame FSM and strobes
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state     <= uart_rx_pkg::idle;
      last_bit  <= uart_rx_pkg::bit_cnt_t'(9);
      byte_done <= 1'b0;
      frame_bad <= 1'b0;
    end
    else
    begin
      byte_done <= 1'b0; // strobes default low
      frame_bad <= 1'b0;
      if (baud_tick)
      begin
        case (state)
          uart_rx_pkg::idle:
          begin
            if (phase == uart_rx_pkg::phase_t'(uart_rx_pkg::START_MID))
            begin
              state <= uart_rx_pkg::data_bits;
              case ({bit8, parity_en}) // frame length for this frame
                2'b00:   last_bit <= uart_rx_pkg::bit_cnt_t'(7);
                2'b11:   last_bit <= uart_rx_pkg::bit_cnt_t'(9);
                default: last_bit <= uart_rx_pkg::bit_cnt_t'(8);
              endcase
            end
          end
          uart_rx_pkg::data_bits:
          begin
            if (last_taken)
            begin
              state     <= uart_rx_pkg::stop_bit;
              byte_done <= 1'b1;
            end
          end
          uart_rx_pkg::stop_bit:
          begin
            if (phase == uart_rx_pkg::phase_t'(uart_rx_pkg::STOP_CHECK_PHASE))
              frame_bad <= !rx_filtered; // stop bit must read high
            else if (phase == uart_rx_pkg::phase_t'(uart_rx_pkg::TICKS_PER_BIT - 1))
              state <= uart_rx_pkg::wait_state;
          end
          default: // wait_state
          begin
            if (rx_filtered ||
                phase == uart_rx_pkg::phase_t'(uart_rx_pkg::WAIT_LIMIT))
              state <= uart_rx_pkg::idle;
          end
        endcase
      end
    end
  end

  //------------------------------------------------------------------
  // bit counter and parity fold
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bit_cnt     <= '0;
      parity_calc <= 1'b0;
    end
    else if (state == uart_rx_pkg::idle)
    begin
      bit_cnt     <= '0;
      parity_calc <= 1'b0;
    end
    else if (sample_now)
    begin
      bit_cnt     <= bit_cnt + 1'b1;
      parity_calc <= parity_calc ^ (parity_en & rx_filtered); // data and parity bit
    end
  end

  // shift register, lsb first, top slot depends on frame format
  always_ff @(posedge clk)
  begin
    if (sample_now)
    begin
      case ({bit8, parity_en})
        2'b00:   rx_shift[uart_rx_pkg::DATA_W-2:0] <=
                   {rx_filtered, rx_shift[uart_rx_pkg::DATA_W-2:1]};
        2'b11:   rx_shift <= {rx_filtered, rx_shift[uart_rx_pkg::DATA_W:1]};
        default: rx_shift[uart_rx_pkg::DATA_W-1:0] <=
                   {rx_filtered, rx_shift[uart_rx_pkg::DATA_W-1:1]};
      endcase
    end
  end

  // top bit is parity or stale in 7-bit frames
  assign rx_data = {bit8 & rx_shift[uart_rx_pkg::DATA_W-1],
                    rx_shift[uart_rx_pkg::DATA_W-2:0]};

  // even: total xor must be 0, odd: must be 1
  assign parity_bad = parity_en & (odd_n_even ? ~parity_calc : parity_calc);

  //------------------------------------------------------------------
  // checks
  //------------------------------------------------------------------
  a_done_pulse: assert property (@(posedge clk) disable iff (!aresetn)
    byte_done |-> $past(baud_tick) ##1 !byte_done);

  a_frame_bad_state: assert property (@(posedge clk) disable iff (!aresetn)
    frame_bad |-> state == uart_rx_pkg::stop_bit);

endmodule

// File: design/rx_line_sampler.sv
//--------------------------------------------------------------------
// rx input synchronizer and three-sample majority glitch filter
//--------------------------------------------------------------------
`timescale 1ns/1ps

module rx_line_sampler
(
  input  logic clk,
  input  logic aresetn,
  input  logic baud_tick,   // 16x bit rate strobe
  input  logic rx,          // raw serial line, async to clk
  output logic rx_filtered  // cleaned line level
);

  logic       rx_meta;  // first sync stage
  logic       rx_sync;  // second sync stage
  logic [2:0] samples;  // newest sample in bit 2

  //------------------------------------------------------------------
  // two-flop synchronizer
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_meta <= 1'b1; // idle line is high
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  //------------------------------------------------------------------
  // sample window, moves once per baud tick
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111;
    end
    else if (baud_tick)
    begin
      samples <= {rx_sync, samples[2:1]}; // oldest drops out of bit 0
    end
  end

  // majority of three, a lone odd sample is ignored
  assign rx_filtered = (samples[0] & samples[1]) |
                       (samples[1] & samples[2]) |
                       (samples[0] & samples[2]);

endmodule

// File: design/rx_status_regs.sv
//--------------------------------------------------------------------
// receive byte register with full, overflow, parity and framing flags
//--------------------------------------------------------------------
`timescale 1ns/1ps

module rx_status_regs
(
  input  logic                  clk,
  input  logic                  aresetn,
  input  logic                  byte_done,           // frame engine strobe
  input  uart_rx_pkg::rx_byte_t rx_data,             // byte from engine
  input  logic                  parity_bad,          // parity result of frame
  input  logic                  frame_bad,           // low stop bit seen
  input  logic                  read_rx_byte,        // host took the byte
  input  logic                  clear_parity,
  input  logic                  clear_framing_error,
  output uart_rx_pkg::rx_byte_t rx_byte,
  output logic                  full,
  output logic                  overflow,
  output logic                  parity_err,
  output logic                  framing_error
);

  //------------------------------------------------------------------
  // byte register, full and overflow
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte  <= '0;
      full     <= 1'b0;
      overflow <= 1'b0;
    end
    else
    begin
      if (read_rx_byte)
      begin
        full     <= 1'b0;
        overflow <= 1'b0;
      end
      if (byte_done) // set beats clear
      begin
        if (full)
          overflow <= 1'b1; // old byte kept, new one dropped
        else
          rx_byte <= rx_data;
        full <= 1'b1;
      end
    end
  end

  //------------------------------------------------------------------
  // error flags
  //------------------------------------------------------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      parity_err    <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (clear_parity)
        parity_err <= 1'b0;
      if (byte_done)
        parity_err <= parity_bad; // updated for every frame, even a dropped one
      if (clear_framing_error)
        framing_error <= 1'b0;
      if (frame_bad)
        framing_error <= 1'b1;
    end
  end

  // overflow only ever raised on top of an unread byte
  a_overflow_full: assert property (@(posedge clk) disable iff (!aresetn)
    overflow |-> full);

endmodule

// File: design/uart_rx.sv
//--------------------------------------------------------------------
// uart receive core top: line sampler, frame engine, status registers
//--------------------------------------------------------------------
`timescale 1ns/1ps

module uart_rx
(
  input  logic                  clk,
  input  logic                  aresetn,
  input  logic                  baud_tick,           // 16x bit rate strobe
  input  logic                  rx,                  // serial input
  input  logic                  bit8,
  input  logic                  parity_en,
  input  logic                  odd_n_even,
  input  logic                  read_rx_byte,
  input  logic                  clear_parity,
  input  logic                  clear_framing_error,
  output uart_rx_pkg::rx_byte_t rx_byte,
  output logic                  full,
  output logic                  overflow,
  output logic                  parity_err,
  output logic                  framing_error
);

  logic                  rx_filtered; // sampler to engine
  logic                  byte_done;
  uart_rx_pkg::rx_byte_t rx_data;
  logic                  parity_bad;
  logic                  frame_bad;

  rx_line_sampler i_line_sampler
  (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx          (rx),
    .rx_filtered (rx_filtered)
  );

  rx_frame_engine i_frame_engine
  (
    .clk         (clk),
    .aresetn     (aresetn),
    .baud_tick   (baud_tick),
    .rx_filtered (rx_filtered),
    .bit8        (bit8),
    .parity_en   (parity_en),
    .odd_n_even  (odd_n_even),
    .byte_done   (byte_done),
    .rx_data     (rx_data),
    .parity_bad  (parity_bad),
    .frame_bad   (frame_bad)
  );

  rx_status_regs i_status_regs
  (
    .clk                 (clk),
    .aresetn             (aresetn),
    .byte_done           (byte_done),
    .rx_data             (rx_data),
    .parity_bad          (parity_bad),
    .frame_bad           (frame_bad),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .full                (full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

endmodule

// File: design/uart_rx_pkg.sv
//--------------------------------------------------------------------
// uart receive frame constants, frame state enum and shared types
//--------------------------------------------------------------------
package uart_rx_pkg;

  //------------------------------------------------------------------
  // frame constants
  //------------------------------------------------------------------
  localparam int DATA_W           = 8;  // received byte width
  localparam int TICKS_PER_BIT    = 16; // baud_tick strobes per serial bit
  localparam int START_MID        = 8;  // low samples to accept a start bit
  localparam int SAMPLE_PHASE     = 15; // data / parity sample point
  localparam int STOP_CHECK_PHASE = 14; // stop bit must be high here
  localparam int WAIT_LIMIT       = 6;  // max ticks waiting for idle line
  localparam int BIT_CNT_W        = 4;  // holds up to 9 bits

  //------------------------------------------------------------------
  // shared types
  //------------------------------------------------------------------
  typedef logic [DATA_W-1:0] rx_byte_t; // received byte

  // tick counter inside one bit period
  typedef logic [$clog2(TICKS_PER_BIT)-1:0] phase_t;

  typedef logic [BIT_CNT_W-1:0] bit_cnt_t; // bits shifted so far

  // receive frame FSM
  typedef enum logic [1:0]
  {
    idle,       // line high, hunting for a start bit
    data_bits,  // shifting data and optional parity
    stop_bit,   // checking the stop bit
    wait_state  // waiting for the line to go back high
  } rx_state_t;

endpackage

// File: project.f
design/uart_rx_pkg.sv
design/rx_line_sampler.sv
design/rx_frame_engine.sv
design/rx_status_regs.sv
design/uart_rx.sv
sim/uart_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the uart receive testbench with Verilator
# the run fails when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module uart_rx_tb \
  -o uart_rx_sim \
  && ./obj_dir/uart_rx_sim > sim.log 2>&1 \
  || { echo "build or simulation aborted"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

// File: sim/uart_rx_stim.txt
# bit8 parity_en odd_n_even data bad_parity low_stop idle_glitch read, all hex
# one frame per line, idle_glitch sends a one-tick low pulse instead of a frame
1 0 0 a5 0 0 0 1
1 0 0 3c 0 0 0 1
1 0 0 ff 0 0 0 1
0 0 0 d5 0 0 0 1
0 1 0 f3 0 0 0 1
0 1 1 81 0 0 0 1
1 1 1 96 0 0 0 1
1 1 0 5a 0 0 0 1
1 1 0 69 1 0 0 1
1 1 1 17 1 0 0 1
0 1 1 2e 1 0 0 1
1 0 0 c3 0 1 0 1
1 1 0 44 0 1 0 1
1 0 0 11 0 0 0 0
1 0 0 22 0 0 0 0
1 0 0 33 0 0 0 1
1 0 0 00 0 0 1 0
1 0 0 e7 0 0 0 1
1 1 1 88 1 0 0 0
1 0 0 99 0 0 0 1

// File: sim/uart_rx_tb.sv
//--------------------------------------------------------------------
// testbench for the uart receive core, frames read from a stim file
//--------------------------------------------------------------------
`timescale 1ns/1ps

module uart_rx_tb;

  localparam int TICK_DIV  = 4;                                     // clk per baud_tick
  localparam int BIT_CLKS  = uart_rx_pkg::TICKS_PER_BIT * TICK_DIV; // clk per serial bit
  localparam int MAX_TESTS = 64;

  logic                  clk = 1'b0;
  logic                  aresetn;
  logic                  baud_tick = 1'b0;
  logic                  rx;
  logic                  bit8;
  logic                  parity_en;
  logic                  odd_n_even;
  logic                  read_rx_byte;
  logic                  clear_parity;
  logic                  clear_framing_error;
  uart_rx_pkg::rx_byte_t rx_byte;
  logic                  full;
  logic                  overflow;
  logic                  parity_err;
  logic                  framing_error;

  // stimulus table, flags are {bit8, parity_en, odd, bad_par, bad_stop, glitch, read}
  logic [7:0]            stim_data  [MAX_TESTS];
  logic [6:0]            stim_flags [MAX_TESTS];
  int                    num_tests   = 0;
  int                    error_count = 0;
  int                    check_count = 0;
  int                    tick_div    = 0;
  integer                seed        = 32'h5000_9f31;
  bit                    stim_loaded = 1'b0;
  longint                watchdog_ns;

  // reference model of the status side
  logic                  full_exp = 1'b0;
  logic                  ovf_exp  = 1'b0;
  logic                  par_exp  = 1'b0;
  logic                  frm_exp  = 1'b0;
  uart_rx_pkg::rx_byte_t byte_exp = '0;

  uart_rx i_uart_rx
  (
    .clk                 (clk),
    .aresetn             (aresetn),
    .baud_tick           (baud_tick),
    .rx                  (rx),
    .bit8                (bit8),
    .parity_en           (parity_en),
    .odd_n_even          (odd_n_even),
    .read_rx_byte        (read_rx_byte),
    .clear_parity        (clear_parity),
    .clear_framing_error (clear_framing_error),
    .rx_byte             (rx_byte),
    .full                (full),
    .overflow            (overflow),
    .parity_err          (parity_err),
    .framing_error       (framing_error)
  );

  always #4 clk = ~clk; // 8 ns period

  // 16x strobe, one clk high out of every four
  always @(negedge clk)
  begin
    if (!aresetn)
    begin
      tick_div  <= 0;
      baud_tick <= 1'b0;
    end
    else
    begin
      tick_div  <= (tick_div == TICK_DIV - 1) ? 0 : tick_div + 1;
      baud_tick <= (tick_div == TICK_DIV - 1);
    end
  end

  //------------------------------------------------------------------
  // compare tasks
  //------------------------------------------------------------------
  task automatic check_byte(input string name, input uart_rx_pkg::rx_byte_t act,
                            input uart_rx_pkg::rx_byte_t exp);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("Error: time %0t, %s = %h, expected %h (engine %s)", $time, name, act, exp,
               i_uart_rx.i_frame_engine.state.name());
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      $display("Error: time %0t, %s = %b, expected %b (engine %s)", $time, name, act, exp,
               i_uart_rx.i_frame_engine.state.name());
    end
  endtask

  //------------------------------------------------------------------
  // stimulus helpers
  //------------------------------------------------------------------
  task automatic load_stimulus();
    int    fd;
    int    cnt;
    string line;
    int    b8, pen, odd, dat, bp, bs, gl, rd;
    fd = $fopen("sim/uart_rx_stim.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the stimulus file sim/uart_rx_stim.txt");
      error_count++;
    end
    else
    begin
      while (!$feof(fd) && num_tests < MAX_TESTS)
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") // skip comments and blank lines
        begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", b8, pen, odd, dat, bp, bs, gl, rd);
          if (cnt == 8)
          begin
            stim_data[num_tests]  = dat[7:0];
            stim_flags[num_tests] = {b8[0], pen[0], odd[0], bp[0], bs[0], gl[0], rd[0]};
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_bit(input logic b);
    rx = b;
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  // start bit, data lsb first, optional parity, stop bit
  task automatic send_frame(input logic [7:0] data, input logic b8, input logic pen,
                            input logic odd, input logic bad_par, input logic bad_stop);
    int   n_data;
    int   i;
    logic par;
    n_data = b8 ? 8 : 7;
    par    = odd ^ bad_par; // even parity bit is the plain xor of the data
    send_bit(1'b0);
    for (i = 0; i < n_data; i++)
    begin
      send_bit(data[i]);
      par ^= data[i];
    end
    if (pen)
      send_bit(par);
    send_bit(!bad_stop);
    rx = 1'b1;
  endtask

  // bounded wait for the byte to land
  task automatic wait_for_full(output logic seen);
    int n;
    seen = full;
    for (n = 0; n < 2 * BIT_CLKS && !seen; n++)
    begin
      @(negedge clk);
      seen = full;
    end
  endtask

  task automatic apply_strobes(input logic rd, input logic cp, input logic cf);
    read_rx_byte        = rd;
    clear_parity        = cp;
    clear_framing_error = cf;
    @(negedge clk);
    read_rx_byte        = 1'b0;
    clear_parity        = 1'b0;
    clear_framing_error = 1'b0;
    @(negedge clk);
  endtask

  //------------------------------------------------------------------
  // watchdog, sized from the number of frames
  //------------------------------------------------------------------
  initial
  begin
    wait (stim_loaded);
    watchdog_ns = longint'(2) * num_tests * 14 * BIT_CLKS * 8;
    #(watchdog_ns);
    $display("watchdog: the tests did not finish within %0d ns", watchdog_ns);
    $display("ERRORS FOUND");
    $finish;
  end

  //------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------
  initial
  begin
    int                    t;
    int                    errs_before;
    int                    gap;
    logic                  seen;
    logic [7:0]            data;
    logic [6:0]            f;
    uart_rx_pkg::rx_byte_t exp_data;

    aresetn             = 1'b0;
    rx                  = 1'b1; // idle line
    bit8                = 1'b1;
    parity_en           = 1'b0;
    odd_n_even          = 1'b0;
    read_rx_byte        = 1'b0;
    clear_parity        = 1'b0;
    clear_framing_error = 1'b0;
    load_stimulus();
    stim_loaded = 1'b1;
    repeat (4) @(negedge clk);
    aresetn = 1'b1;
    @(negedge clk);

    check_byte("rx_byte", rx_byte, '0);
    check_flag("full", full, 1'b0);
    check_flag("overflow", overflow, 1'b0);
    check_flag("parity_err", parity_err, 1'b0);
    check_flag("framing_error", framing_error, 1'b0);
    $display("test reset: %0d errors", error_count);

    if (num_tests == 0)
    begin
      $display("no tests were loaded from the stimulus file");
      error_count++;
    end

    for (t = 0; t < num_tests; t++)
    begin
      errs_before = error_count;
      data        = stim_data[t];
      f           = stim_flags[t];
      bit8        = f[6]; // format changes only while the line idles
      parity_en   = f[5];
      odd_n_even  = f[4];
      gap         = $random(seed);
      repeat (2 + (gap & 3)) send_bit(1'b1);

      if (f[1])
      begin
        rx = 1'b0; // low for one tick only
        repeat (TICK_DIV) @(negedge clk);
        rx = 1'b1;
        repeat (2 * BIT_CLKS) @(negedge clk);
        check_flag("full", full, full_exp);
        check_byte("rx_byte", rx_byte, byte_exp);
      end
      else
      begin
        exp_data = bit8 ? data : {1'b0, data[6:0]};
        if (full_exp)
          ovf_exp = 1'b1; // unread byte, new one dropped
        else
        begin
          byte_exp = exp_data;
          full_exp = 1'b1;
        end
        par_exp = parity_en & f[3];
        frm_exp = f[2];
        send_frame(data, bit8, parity_en, odd_n_even, f[3], f[2]);
        wait_for_full(seen);
        if (!seen)
        begin
          $display("test %0d: full never went high after the stop bit", t);
          error_count++;
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_byte("rx_byte", rx_byte, byte_exp);
        check_flag("full", full, full_exp);
        check_flag("overflow", overflow, ovf_exp);
        check_flag("parity_err", parity_err, par_exp);
        check_flag("framing_error", framing_error, frm_exp);
        if (par_exp || frm_exp)
        begin
          apply_strobes(1'b0, par_exp, frm_exp);
          par_exp = 1'b0;
          frm_exp = 1'b0;
          check_flag("parity_err", parity_err, par_exp);
          check_flag("framing_error", framing_error, frm_exp);
        end
        if (f[0])
        begin
          apply_strobes(1'b1, 1'b0, 1'b0); // host reads the byte
          full_exp = 1'b0;
          ovf_exp  = 1'b0;
          check_flag("full", full, full_exp);
          check_flag("overflow", overflow, ovf_exp);
        end
      end
      $display("test %0d: %s data %h bit8 %0d parity %0d odd %0d, %0d errors", t,
               f[1] ? "glitch" : "frame", data, bit8, parity_en, odd_n_even,
               error_count - errs_before);
    end

    $display("summary: %0d tests, %0d checks, %0d errors", num_tests, check_count,
             error_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule
